/* rtl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	// instruction and address width
	localparam int xlen = 32;

	// compressed instructions are one half-word
	localparam int half_w = xlen / 2;

	// bytes per instruction memory word, as sent over the uart
	localparam int word_bytes = xlen / 8;

	// fetch starts here after reset and after every program load
	localparam logic [xlen-1:0] reset_vector = 32'h0000_0000;

	////////////////////////////////////////
	// redirect command from the back end
	////////////////////////////////////////

	typedef enum logic [2:0] {
		// no redirect this cycle
		redir_none     = 3'd0,
		// redir_pc + redir_off
		redir_branch   = 3'd1,
		// same rule as branch
		redir_jal      = 3'd2,
		// redir_off as absolute address, bit 0 cleared
		redir_jalr     = 3'd3,
		// jump to mtvec
		redir_trap     = 3'd4,
		// back to mepc
		redir_trap_ret = 3'd5
	} redir_e;

endpackage

`default_nettype wire

/* rtl/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
	parameter int clks_per_bit = 8
) (
	input  logic       bus,
	input  logic       arst_n,
	input  logic       rx,
	output logic [7:0] rx_data,
	output logic       rx_strobe
);

	localparam int cw = $clog2(clks_per_bit);

	typedef enum logic [1:0] {
		idle,
		start,
		data,
		stop
	} state_e;

	state_e state;
	logic rx_q;
	logic [cw-1:0] cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic bit_done;
	logic start_mid;

	// end of a full bit period, counted from the previous sample point
	assign bit_done = (cnt == cw'(clks_per_bit - 1));
	// middle of the start bit
	assign start_mid = (cnt == cw'(clks_per_bit / 2 - 1));

	assign rx_data = shift;

	always_ff @(posedge bus or negedge arst_n) begin
		if (!arst_n) begin
			state <= idle;
			cnt <= '0;
			bit_idx <= '0;
			rx_strobe <= 1'b0;
			// line idles high
			rx_q <= 1'b1;
		end else begin
			rx_q <= rx;
			rx_strobe <= 1'b0;
			case (state)
				idle: begin
					// falling edge, possible start bit
					if (!rx_q) begin
						state <= start;
						cnt <= '0;
					end
				end
				start: begin
					if (start_mid) begin
						cnt <= '0;
						bit_idx <= '0;
						// glitch, line already back high
						state <= rx_q ? idle : data;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				data: begin
					if (bit_done) begin
						cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= stop;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				stop: begin
					// no strobe on a framing error
					if (bit_done) begin
						rx_strobe <= rx_q;
						state <= idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// lsb first into the top of the shifter
	always_ff @(posedge bus) begin
		if (state == data && bit_done) begin
			shift <= {rx_q, shift[7:1]};
		end
	end

endmodule

`default_nettype wire

/* rtl/imem_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module imem_loader
	import fetch_pkg::*;
#(
	parameter int imem_words = 256
) (
	input  logic                          bus,
	input  logic                          arst_n,
	input  logic                          prog,
	input  logic [7:0]                    rx_data,
	input  logic                          rx_strobe,
	output logic                          load_active,
	output logic                          wr_en,
	output logic [$clog2(imem_words)-1:0] wr_addr,
	output logic [xlen-1:0]               wr_data
);

	localparam int aw = $clog2(imem_words);
	localparam int bw = $clog2(word_bytes);

	logic prog_q;
	logic [bw-1:0] byte_cnt;
	logic [xlen-1:0] word_q;

	// high from the first prog cycle until one cycle after prog drops
	assign load_active = prog | prog_q;
	assign wr_data = word_q;

	always_ff @(posedge bus or negedge arst_n) begin
		if (!arst_n) begin
			prog_q <= 1'b0;
			byte_cnt <= '0;
			wr_en <= 1'b0;
			wr_addr <= '0;
		end else begin
			prog_q <= prog;
			wr_en <= 1'b0;
			if (!prog) begin
				// partial word dropped, next load starts at word 0
				byte_cnt <= '0;
				wr_addr <= '0;
			end else begin
				if (rx_strobe) begin
					if (byte_cnt == bw'(word_bytes - 1)) begin
						byte_cnt <= '0;
						wr_en <= 1'b1;
					end else begin
						byte_cnt <= byte_cnt + 1'b1;
					end
				end
				// step once the write has gone out
				if (wr_en) begin
					if (wr_addr == aw'(imem_words - 1)) begin
						wr_addr <= '0;
					end else begin
						wr_addr <= wr_addr + 1'b1;
					end
				end
			end
		end
	end

	// bytes come lsb first, so shift down from the top
	always_ff @(posedge bus) begin
		if (prog && rx_strobe) begin
			word_q <= {rx_data, word_q[xlen-1:8]};
		end
	end

endmodule

`default_nettype wire

/* rtl/imem.sv */
`timescale 1ns/1ps
`default_nettype none

module imem
	import fetch_pkg::*;
#(
	parameter int imem_words = 256
) (
	input  logic                          bus,
	input  logic                          wr_en,
	input  logic [$clog2(imem_words)-1:0] wr_addr,
	input  logic [xlen-1:0]               wr_data,
	input  logic                          rd_en,
	input  logic [$clog2(imem_words)-1:0] rd_addr,
	output logic [xlen-1:0]               rd_data
);

	////////////////////////////////////////
	// storage
	////////////////////////////////////////

	// one instruction word per entry
	logic [xlen-1:0] mem [imem_words];

	// write port, loader side
	always_ff @(posedge bus) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read
	// output holds while rd_en is low, fetch relies on that under stall
	always_ff @(posedge bus) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
	import fetch_pkg::*;
#(
	parameter int imem_words = 256
) (
	input  logic                          bus,
	input  logic                          arst_n,
	input  logic                          load_active,
	output logic                          rd_en,
	output logic [$clog2(imem_words)-1:0] rd_addr,
	input  logic [xlen-1:0]               rd_data,
	input  redir_e                        redir_kind,
	input  logic [xlen-1:0]               redir_pc,
	input  logic [xlen-1:0]               redir_off,
	input  logic [xlen-1:0]               mtvec,
	input  logic [xlen-1:0]               mepc,
	output logic                          out_valid,
	output logic [xlen-1:0]               out_pc,
	output logic [xlen-1:0]               out_ins,
	output logic                          out_comp,
	input  logic                          out_ready
);

	localparam int aw = $clog2(imem_words);

	// address slot, pending restart address
	logic addr_valid;
	logic [xlen-1:0] fetch_pc;
	// output slot, pc of the word now on rd_data
	logic slot_valid;
	logic [xlen-1:0] slot_pc;

	logic [half_w-1:0] half;
	logic comp;
	logic [xlen-1:0] seq_pc;
	logic [xlen-1:0] fetch_addr;
	logic [xlen-1:0] redir_target;
	logic redir_taken;
	logic advance;

	////////////////////////////////////////
	// compressed detect and step
	////////////////////////////////////////

	// pc bit 1 picks the half-word
	assign half = slot_pc[1] ? rd_data[xlen-1:half_w] : rd_data[half_w-1:0];
	// all-zero half is illegal, treat as 32-bit
	assign comp = (half[1:0] != 2'b11) && (half != '0);
	assign seq_pc = slot_pc + (comp ? xlen'(2) : xlen'(4));

	////////////////////////////////////////
	// next address
	////////////////////////////////////////

	// trap return first, then trap entry, then branch/jump
	always_comb begin
		redir_taken = 1'b1;
		case (redir_kind)
			redir_trap_ret: redir_target = mepc;
			redir_trap: redir_target = mtvec;
			redir_branch,
			redir_jal: redir_target = redir_pc + redir_off;
			redir_jalr: redir_target = {redir_off[xlen-1:1], 1'b0};
			default: begin
				redir_taken = 1'b0;
				redir_target = fetch_pc;
			end
		endcase
	end

	// restart address, else sequential from the output slot
	assign fetch_addr = addr_valid ? fetch_pc : seq_pc;

	// read when restarting or when decode takes the current word
	assign advance = !load_active && (addr_valid || (slot_valid && out_ready));
	assign rd_en = advance;
	assign rd_addr = fetch_addr[aw+1:2];

	////////////////////////////////////////
	// slot state
	////////////////////////////////////////

	always_ff @(posedge bus or negedge arst_n) begin
		if (!arst_n) begin
			addr_valid <= 1'b0;
			slot_valid <= 1'b0;
			fetch_pc <= reset_vector;
			slot_pc <= reset_vector;
		end else if (load_active) begin
			// ram being rewritten, park at the reset vector
			addr_valid <= 1'b0;
			slot_valid <= 1'b0;
			fetch_pc <= reset_vector;
		end else if (redir_taken) begin
			// flush both slots, target read next cycle
			addr_valid <= 1'b1;
			slot_valid <= 1'b0;
			fetch_pc <= redir_target;
		end else if (!addr_valid && !slot_valid) begin
			// empty after reset or load, arm the first read
			addr_valid <= 1'b1;
		end else if (advance) begin
			addr_valid <= 1'b0;
			slot_valid <= 1'b1;
			slot_pc <= fetch_addr;
			fetch_pc <= fetch_addr;
		end
	end

	////////////////////////////////////////
	// decode side
	////////////////////////////////////////

	// stable under stall, ram output and slot_pc both hold
	assign out_valid = slot_valid && !load_active;
	assign out_pc = slot_pc;
	assign out_ins = comp ? {{half_w{1'b0}}, half} : rd_data;
	assign out_comp = comp;

endmodule

`default_nettype wire

/* rtl/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top
	import fetch_pkg::*;
#(
	parameter int imem_words = 256,
	parameter int clks_per_bit = 8
) (
	input  logic            bus,
	input  logic            arst_n,
	input  logic            rx,
	input  logic            prog,
	input  redir_e          redir_kind,
	input  logic [xlen-1:0] redir_pc,
	input  logic [xlen-1:0] redir_off,
	input  logic [xlen-1:0] mtvec,
	input  logic [xlen-1:0] mepc,
	output logic            out_valid,
	output logic [xlen-1:0] out_pc,
	output logic [xlen-1:0] out_ins,
	output logic            out_comp,
	input  logic            out_ready
);

	localparam int aw = $clog2(imem_words);

	// uart to loader
	logic [7:0] rx_data;
	logic rx_strobe;
	// loader to ram and fetch
	logic load_active;
	logic wr_en;
	logic [aw-1:0] wr_addr;
	logic [xlen-1:0] wr_data;
	// fetch to ram
	logic rd_en;
	logic [aw-1:0] rd_addr;
	logic [xlen-1:0] rd_data;

	////////////////////////////////////////
	// program load path
	////////////////////////////////////////

	uart_rx #(
		.clks_per_bit(clks_per_bit)
	) uart_rx0 (
		.bus(bus),
		.arst_n(arst_n),
		.rx(rx),
		.rx_data(rx_data),
		.rx_strobe(rx_strobe)
	);

	imem_loader #(
		.imem_words(imem_words)
	) imem_loader0 (
		.bus(bus),
		.arst_n(arst_n),
		.prog(prog),
		.rx_data(rx_data),
		.rx_strobe(rx_strobe),
		.load_active(load_active),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data)
	);

	////////////////////////////////////////
	// memory and fetch
	////////////////////////////////////////

	imem #(
		.imem_words(imem_words)
	) imem0 (
		.bus(bus),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	fetch_stage #(
		.imem_words(imem_words)
	) fetch_stage0 (
		.bus(bus),
		.arst_n(arst_n),
		.load_active(load_active),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.redir_kind(redir_kind),
		.redir_pc(redir_pc),
		.redir_off(redir_off),
		.mtvec(mtvec),
		.mepc(mepc),
		.out_valid(out_valid),
		.out_pc(out_pc),
		.out_ins(out_ins),
		.out_comp(out_comp),
		.out_ready(out_ready)
	);

endmodule

`default_nettype wire

/* bench/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb
	import fetch_pkg::*;
();

	localparam int bit_clks = 4;
	localparam int prog_len = 12;
	localparam int n_runs = 30;
	localparam int clk_ns = 100;
	// per entry bound covers the worst stall and a redirect
	localparam int entry_ns = 20 * clk_ns;
	// two loads of 10-bit frames
	localparam int load_ns = 2 * prog_len * word_bytes * 10 * bit_clks * clk_ns;
	localparam int timeout_ns = n_runs * entry_ns + load_ns;

	// word shapes in the program table
	localparam int shape_wide = 0;
	localparam int shape_comp = 1;
	localparam int shape_zero = 2;

	// mtvec points at word 8 and mepc at the upper half of word 6
	localparam logic [xlen-1:0] trap_vec = 32'h20;
	localparam logic [xlen-1:0] trap_ret_pc = 32'h1a;

	logic bus;
	logic arst_n;
	logic rx;
	logic prog;
	redir_e redir_kind;
	logic [xlen-1:0] redir_pc;
	logic [xlen-1:0] redir_off;
	logic [xlen-1:0] mtvec;
	logic [xlen-1:0] mepc;
	logic out_valid;
	logic [xlen-1:0] out_pc;
	logic [xlen-1:0] out_ins;
	logic out_comp;
	logic out_ready;

	integer seed;
	// program image as the model sees it
	logic [xlen-1:0] prog_words [prog_len];
	logic [xlen-1:0] model_pc;

	// run table with one accepted instruction per entry
	logic run_load [n_runs];
	redir_e run_kind [n_runs];
	logic [xlen-1:0] run_rpc [n_runs];
	logic [xlen-1:0] run_off [n_runs];
	int run_stall [n_runs];
	logic [xlen-1:0] run_pc [n_runs];
	int n_built;

	fetch_top #(
		.imem_words(256),
		.clks_per_bit(bit_clks)
	) dut0 (
		.bus(bus),
		.arst_n(arst_n),
		.rx(rx),
		.prog(prog),
		.redir_kind(redir_kind),
		.redir_pc(redir_pc),
		.redir_off(redir_off),
		.mtvec(mtvec),
		.mepc(mepc),
		.out_valid(out_valid),
		.out_pc(out_pc),
		.out_ins(out_ins),
		.out_comp(out_comp),
		.out_ready(out_ready)
	);

	initial begin
		bus = 1'b0;
		forever #(clk_ns / 2) bus = ~bus;
	end

	////////////////////////////////////////
	// error reporting
	////////////////////////////////////////

	task automatic value_error(input string what, input logic [xlen-1:0] got,
		input logic [xlen-1:0] exp);
		$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		$display("Testbench failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "run aborted");
	endtask

	// hang guard sized from the table and the uart traffic
	initial begin
		#(timeout_ns);
		abort_run($sformatf("no result after %0d ns, the run appears to hang", timeout_ns));
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	function automatic logic [half_w-1:0] pick_half(input logic [xlen-1:0] pc);
		logic [xlen-1:0] word;
		word = prog_words[int'(pc >> 2)];
		// pc bit 1 selects upper or lower half
		return pc[1] ? word[xlen-1:half_w] : word[half_w-1:0];
	endfunction

	function automatic logic expect_comp(input logic [xlen-1:0] pc);
		logic [half_w-1:0] h;
		h = pick_half(pc);
		return (h[1:0] != 2'b11) && (h != '0);
	endfunction

	function automatic logic [xlen-1:0] expect_ins(input logic [xlen-1:0] pc);
		if (expect_comp(pc)) begin
			return {{half_w{1'b0}}, pick_half(pc)};
		end
		return prog_words[int'(pc >> 2)];
	endfunction

	function automatic logic [xlen-1:0] redirect_target(input redir_e kind,
		input logic [xlen-1:0] rpc, input logic [xlen-1:0] off);
		case (kind)
			redir_branch, redir_jal: return rpc + off;
			// absolute target with the low bit dropped
			redir_jalr: return off & ~32'h1;
			redir_trap: return mtvec;
			redir_trap_ret: return mepc;
			default: return model_pc;
		endcase
	endfunction

	////////////////////////////////////////
	// program table
	////////////////////////////////////////

	function automatic int word_shape(input int w);
		case (w)
			1, 4, 6, 9: return shape_comp;
			3: return shape_zero;
			default: return shape_wide;
		endcase
	endfunction

	// quadrant 0..2 with bit 2 set so never all zero
	function automatic logic [half_w-1:0] comp_half(input logic [half_w-1:0] r);
		return {r[half_w-1:3], 1'b1, ((r[1:0] == 2'b11) ? 2'b10 : r[1:0])};
	endfunction

	task automatic make_program();
		logic [xlen-1:0] r;
		for (int w = 0; w < prog_len; w++) begin
			r = $random(seed);
			case (word_shape(w))
				shape_comp: prog_words[w] = {comp_half(r[31:16]), comp_half(r[15:0])};
				shape_zero: prog_words[w] = '0;
				// full word with opcode low bits 11
				default: prog_words[w] = {r[31:2], 2'b11};
			endcase
		end
	endtask

	////////////////////////////////////////
	// uart and load
	////////////////////////////////////////

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		// start bit at bit 0 and stop bit at bit 9
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge bus);
			rx <= frame[i];
			repeat (bit_clks - 1) begin
				@(negedge bus);
				assert (!out_valid) else abort_run("out_valid went high during a program load");
				@(posedge bus);
			end
		end
	endtask

	task automatic load_program();
		@(posedge bus);
		prog <= 1'b1;
		out_ready <= 1'b0;
		@(negedge bus);
		assert (!out_valid) else abort_run("fetch kept offering instructions after prog rose");
		for (int w = 0; w < prog_len; w++) begin
			for (int k = 0; k < word_bytes; k++) begin
				send_byte(prog_words[w][8*k +: 8]);
			end
		end
		// last strobe and write still in flight
		repeat (4 * bit_clks) @(posedge bus);
		prog <= 1'b0;
		@(negedge bus);
		while (dut0.load_active) @(negedge bus);
		// first instruction exactly two cycles after load_active falls
		assert (!out_valid) else abort_run("out_valid high as load_active fell");
		@(negedge bus);
		assert (!out_valid) else abort_run("out_valid high one cycle after the load");
		@(negedge bus);
		assert (out_valid) else abort_run("reset vector not offered two cycles after the load");
		check_output(reset_vector);
	endtask

	////////////////////////////////////////
	// decode side
	////////////////////////////////////////

	task automatic check_output(input logic [xlen-1:0] pc);
		logic [xlen-1:0] ins;
		logic comp;
		ins = expect_ins(pc);
		comp = expect_comp(pc);
		assert (out_pc === pc) else value_error("out_pc", out_pc, pc);
		assert (out_ins === ins) else value_error("out_ins", out_ins, ins);
		assert (out_comp === comp) else value_error("out_comp", {31'b0, out_comp}, {31'b0, comp});
	endtask

	// returns at the negedge before the transfer edge
	task automatic take(input int stalls, input logic back_to_back);
		int waited;
		logic first;
		logic done;
		logic [xlen-1:0] snap_pc;
		logic [xlen-1:0] snap_ins;
		logic snap_comp;
		waited = 0;
		first = 1'b1;
		done = 1'b0;
		snap_pc = '0;
		snap_ins = '0;
		snap_comp = 1'b0;
		while (!done) begin
			@(posedge bus);
			out_ready <= (waited >= stalls);
			@(negedge bus);
			// sequential word follows the last transfer directly
			assert (out_valid || !(first && back_to_back))
				else abort_run("bubble between sequential instructions");
			first = 1'b0;
			if (waited > 0) begin
				assert (out_valid) else abort_run("out_valid dropped before decode took it");
				assert (out_pc === snap_pc) else value_error("stalled out_pc", out_pc, snap_pc);
				assert (out_ins === snap_ins) else value_error("stalled out_ins", out_ins, snap_ins);
				assert (out_comp === snap_comp)
					else value_error("stalled out_comp", {31'b0, out_comp}, {31'b0, snap_comp});
			end
			if (out_valid && out_ready) begin
				done = 1'b1;
			end else if (out_valid) begin
				if (waited == 0) begin
					snap_pc = out_pc;
					snap_ins = out_ins;
					snap_comp = out_comp;
				end
				waited++;
			end
		end
	endtask

	task automatic redirect(input redir_e kind, input logic [xlen-1:0] rpc,
		input logic [xlen-1:0] off, input logic [xlen-1:0] target);
		@(posedge bus);
		out_ready <= 1'b0;
		redir_kind <= kind;
		redir_pc <= rpc;
		redir_off <= off;
		// command sampled at the end of cycle n
		@(posedge bus);
		redir_kind <= redir_none;
		@(negedge bus);
		assert (!out_valid) else abort_run("out_valid high on the cycle after a redirect");
		@(negedge bus);
		assert (out_valid) else abort_run("redirect target missing two cycles after the command");
		assert (out_pc === target) else value_error("redirect out_pc", out_pc, target);
	endtask

	////////////////////////////////////////
	// run table
	////////////////////////////////////////

	function automatic int rand_stall();
		return $random(seed) & 3;
	endfunction

	task automatic add_run(input logic load, input redir_e kind, input logic [xlen-1:0] rpc,
		input logic [xlen-1:0] off, input int stall, input logic [xlen-1:0] pc);
		run_load[n_built] = load;
		run_kind[n_built] = kind;
		run_rpc[n_built] = rpc;
		run_off[n_built] = off;
		run_stall[n_built] = stall;
		run_pc[n_built] = pc;
		n_built++;
	endtask

	task automatic build_runs();
		n_built = 0;
		// first load and straight-line fetch
		add_run(1'b1, redir_none, 32'h0, 32'h0, 0, 32'h00);
		add_run(1'b0, redir_none, 32'h0, 32'h0, 0, 32'h04);
		add_run(1'b0, redir_none, 32'h0, 32'h0, 0, 32'h06);
		add_run(1'b0, redir_none, 32'h0, 32'h0, 0, 32'h08);
		// all-zero word steps by 4
		add_run(1'b0, redir_none, 32'h0, 32'h0, 0, 32'h0c);
		add_run(1'b0, redir_none, 32'h0, 32'h0, 0, 32'h10);
		// back-pressure
		add_run(1'b0, redir_none, 32'h0, 32'h0, rand_stall(), 32'h12);
		add_run(1'b0, redir_none, 32'h0, 32'h0, rand_stall(), 32'h14);
		add_run(1'b0, redir_none, 32'h0, 32'h0, rand_stall(), 32'h18);
		add_run(1'b0, redir_none, 32'h0, 32'h0, rand_stall(), 32'h1a);
		add_run(1'b0, redir_none, 32'h0, 32'h0, rand_stall(), 32'h1c);
		// redirects
		add_run(1'b0, redir_branch, 32'h1c, 32'h08, 0, 32'h24);
		add_run(1'b0, redir_none, 32'h0, 32'h0, 0, 32'h26);
		add_run(1'b0, redir_jal, 32'h26, 32'hffff_ffde, 1, 32'h04);
		add_run(1'b0, redir_none, 32'h0, 32'h0, 0, 32'h06);
		add_run(1'b0, redir_jalr, 32'h0, 32'h19, 0, 32'h18);
		add_run(1'b0, redir_none, 32'h0, 32'h0, 2, 32'h1a);
		add_run(1'b0, redir_trap, 32'h0, 32'h0, 0, trap_vec);
		add_run(1'b0, redir_none, 32'h0, 32'h0, 0, 32'h24);
		add_run(1'b0, redir_trap_ret, 32'h0, 32'h0, 1, trap_ret_pc);
		add_run(1'b0, redir_none, 32'h0, 32'h0, 0, 32'h1c);
		// reprogram mid-run
		add_run(1'b1, redir_none, 32'h0, 32'h0, 0, 32'h00);
		add_run(1'b0, redir_none, 32'h0, 32'h0, rand_stall(), 32'h04);
		add_run(1'b0, redir_none, 32'h0, 32'h0, rand_stall(), 32'h06);
		add_run(1'b0, redir_none, 32'h0, 32'h0, 0, 32'h08);
		add_run(1'b0, redir_none, 32'h0, 32'h0, 0, 32'h0c);
		add_run(1'b0, redir_jalr, 32'h0, 32'h2d, 0, 32'h2c);
		add_run(1'b0, redir_branch, 32'h2c, 32'hffff_fff0, 1, 32'h1c);
		add_run(1'b0, redir_none, 32'h0, 32'h0, 0, 32'h20);
		add_run(1'b0, redir_none, 32'h0, 32'h0, rand_stall(), 32'h24);
		assert (n_built == n_runs) else abort_run("run table size does not match n_runs");
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		seed = 32'hb32b;
		arst_n = 1'b0;
		rx = 1'b1;
		prog = 1'b0;
		redir_kind = redir_none;
		redir_pc = '0;
		redir_off = '0;
		mtvec = trap_vec;
		mepc = trap_ret_pc;
		out_ready = 1'b0;
		model_pc = reset_vector;
		build_runs();
		// reset held over four rising edges
		repeat (3) @(posedge bus);
		@(negedge bus);
		assert (!out_valid) else abort_run("out_valid high during reset");
		@(posedge bus);
		arst_n <= 1'b1;
		for (int i = 0; i < n_runs; i++) begin
			if (run_load[i]) begin
				make_program();
				model_pc = reset_vector;
				load_program();
			end else if (run_kind[i] != redir_none) begin
				model_pc = redirect_target(run_kind[i], run_rpc[i], run_off[i]);
				redirect(run_kind[i], run_rpc[i], run_off[i], model_pc);
			end
			assert (run_pc[i] === model_pc)
				else abort_run($sformatf("run entry %0d disagrees with the reference model", i));
			take(run_stall[i], !run_load[i] && run_kind[i] == redir_none && i > 0);
			check_output(model_pc);
			// step by the rule for the word just taken
			model_pc = model_pc + (expect_comp(model_pc) ? 32'd2 : 32'd4);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

/* mini_fetch.f */
rtl/fetch_pkg.sv
rtl/uart_rx.sv
rtl/imem_loader.sv
rtl/imem.sv
rtl/fetch_stage.sv
rtl/fetch_top.sv
bench/fetch_tb.sv

/* Makefile */
# Verilator build and run of the fetch subsystem testbench

VERILATOR ?= verilator
TOP ?= fetch_tb
FILELIST ?= mini_fetch.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

# the simulator exits non-zero on a failed run
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
